//--- Makefile
# Verilator build and run for the trace capture testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_capture
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
src/trace_pkg.sv
src/trace_nibble_decode.sv
src/pattern_match_unit.sv
src/trigger_pulse_gen.sv
src/capture_record_gen.sv
src/trace_capture_top.sv
tests/tb_clock_gen.sv
tests/tb_trace_capture.sv

//--- src/capture_record_gen.sv
// ==================================================
// capture record generator
// timestamp since arm and one record per match
// ==================================================

`timescale 1ns/1ps

module capture_record_gen (
   input  logic                               trace_clk,
   input  logic                               reset,
   input  logic                               arm,
   input  trace_pkg::hit_vector_t             hits,
   input  logic [trace_pkg::BUFFER_WIDTH-1:0] match_bytes,
   output logic                               record_valid,
   output trace_pkg::capture_record_t         record
);

   logic [trace_pkg::TIMESTAMP_WIDTH-1:0]  timestamp;
   logic [trace_pkg::RULE_INDEX_WIDTH-1:0] first_rule;

   // zero in the first armed cycle, sticks at all ones
   always_ff @(posedge trace_clk) begin
      if (reset || !arm) timestamp <= '0;
      else if (timestamp != '1) timestamp <= timestamp + 1'b1;
   end

   // priority encoder, lowest index wins
   always_comb begin
      first_rule = '0;
      for (int i = trace_pkg::NUM_RULES - 1; i >= 0; i--) begin
         if (hits[i]) first_rule = i[trace_pkg::RULE_INDEX_WIDTH-1:0];
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset || !arm) record_valid <= 1'b0;
      else record_valid <= |hits;
   end

   always_ff @(posedge trace_clk) begin
      if (|hits) begin
         record.rule_index  <= first_rule;
         record.timestamp   <= timestamp;   // time of the hit cycle
         record.match_bytes <= match_bytes;
      end
   end

   a_record_from_hit: assert property (
      @(posedge trace_clk) disable iff (reset)
      record_valid |-> ($past(hits) != '0)
   );

endmodule

//--- src/pattern_match_unit.sv
// ==================================================
// pattern match unit
// masked compare of the buffer against every rule,
// registered hit vector and per rule hit counters
// ==================================================

`timescale 1ns/1ps

module pattern_match_unit (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  logic                                  arm,
   input  logic                                  byte_valid,
   input  logic [trace_pkg::BUFFER_WIDTH-1:0]    match_buffer,
   input  trace_pkg::match_rule_t                rules [trace_pkg::NUM_RULES],
   output trace_pkg::hit_vector_t                hits,
   output logic                                  trig_hit,
   output logic [trace_pkg::BUFFER_WIDTH-1:0]    match_bytes,
   output logic [trace_pkg::HIT_COUNT_WIDTH-1:0] hit_counts [trace_pkg::NUM_RULES]
);

   trace_pkg::hit_vector_t hit_next;
   trace_pkg::hit_vector_t trig_mask;   // rules allowed to trigger

   // all rules compared in parallel
   always_comb begin
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         hit_next[i] = rules[i].enable && byte_valid &&
                       (((match_buffer ^ rules[i].pattern) & rules[i].mask) == '0);
         trig_mask[i] = rules[i].trig_enable;
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset || !arm) begin
         hits     <= '0;
         trig_hit <= 1'b0;
      end else begin
         hits     <= hit_next;
         trig_hit <= |(hit_next & trig_mask);
      end
   end

   // buffer snapshot travels with the hit vector
   always_ff @(posedge trace_clk) begin
      if (byte_valid) begin
         match_bytes <= match_buffer;
      end
   end

   // saturating counters, cleared on disarm
   always_ff @(posedge trace_clk) begin
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         if (reset || !arm) begin
            hit_counts[i] <= '0;
         end else if (hit_next[i] && (hit_counts[i] != '1)) begin
            hit_counts[i] <= hit_counts[i] + 1'b1;
         end
      end
   end

   // a hit only ever follows a completed byte
   a_hits_follow_byte: assert property (
      @(posedge trace_clk) disable iff (reset)
      !byte_valid |=> (hits == '0)
   );

endmodule

//--- src/trace_capture_top.sv
// ==================================================
// trace capture top
// nibble decode, pattern match, trigger and capture
// record stages on the trace clock
// ==================================================

`timescale 1ns/1ps

module trace_capture_top (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  logic [trace_pkg::NIBBLE_WIDTH-1:0]    trace_data,
   input  logic                                  arm,
   input  trace_pkg::match_rule_t                rules [trace_pkg::NUM_RULES],
   input  trace_pkg::trigger_cfg_t               trig_cfg,
   output logic                                  trig_out,
   output logic                                  record_valid,
   output trace_pkg::capture_record_t            record,
   output logic [trace_pkg::HIT_COUNT_WIDTH-1:0] hit_counts [trace_pkg::NUM_RULES]
);

   logic                               byte_valid;
   logic [trace_pkg::BUFFER_WIDTH-1:0] match_buffer;
   trace_pkg::hit_vector_t             hits;
   logic                               trig_hit;
   logic [trace_pkg::BUFFER_WIDTH-1:0] match_bytes;

   trace_nibble_decode trace_nibble_decode_i (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .trace_data   (trace_data),
      .byte_valid   (byte_valid),
      .match_buffer (match_buffer)
   );

   pattern_match_unit pattern_match_unit_i (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .byte_valid   (byte_valid),
      .match_buffer (match_buffer),
      .rules        (rules),
      .hits         (hits),
      .trig_hit     (trig_hit),
      .match_bytes  (match_bytes),
      .hit_counts   (hit_counts)
   );

   trigger_pulse_gen trigger_pulse_gen_i (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .trig_hit     (trig_hit),
      .trig_cfg     (trig_cfg),
      .trig_out     (trig_out)
   );

   capture_record_gen capture_record_gen_i (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .hits         (hits),
      .match_bytes  (match_bytes),
      .record_valid (record_valid),
      .record       (record)
   );

endmodule

//--- src/trace_nibble_decode.sv
// ==================================================
// trace nibble decode
// pairs port nibbles into bytes, low nibble first,
// and shifts each byte into the match buffer
// ==================================================

`timescale 1ns/1ps

module trace_nibble_decode (
   input  logic                                 trace_clk,
   input  logic                                 reset,
   input  logic                                 arm,
   input  logic [trace_pkg::NIBBLE_WIDTH-1:0]   trace_data,
   output logic                                 byte_valid,
   output logic [trace_pkg::BUFFER_WIDTH-1:0]   match_buffer
);

   logic                               high_phase;  // next nibble completes a byte
   logic [trace_pkg::NIBBLE_WIDTH-1:0] low_nibble;

   // phase, strobe and buffer all restart when arm drops
   always_ff @(posedge trace_clk) begin
      if (reset || !arm) begin
         high_phase   <= 1'b0;
         byte_valid   <= 1'b0;
         match_buffer <= '0;
      end else begin
         high_phase <= !high_phase;
         byte_valid <= high_phase;   // one cycle, after the high nibble
         if (high_phase) begin
            // newest byte at the bottom, oldest falls off the top
            match_buffer <= {match_buffer[trace_pkg::BUFFER_WIDTH-9:0],
                             trace_data, low_nibble};
         end
      end
   end

   // holds the first half of the byte
   always_ff @(posedge trace_clk) begin
      if (!high_phase) begin
         low_nibble <= trace_data;
      end
   end

   // phase toggles every armed cycle, so bytes are at least two cycles apart
   a_byte_valid_spaced: assert property (
      @(posedge trace_clk) disable iff (reset)
      byte_valid |=> !byte_valid
   );

endmodule

//--- src/trace_pkg.sv
// ==================================================
// trace capture package
// sizes, match rules, trigger settings and the
// capture record shared by the trace front end
// ==================================================

package trace_pkg;

   // trace port and match buffer
   localparam int NIBBLE_WIDTH = 4;
   localparam int BUFFER_BYTES = 8;
   localparam int BUFFER_WIDTH = BUFFER_BYTES * 8;

   // pattern rules
   localparam int NUM_RULES = 8;
   localparam int RULE_INDEX_WIDTH = $clog2(NUM_RULES);
   localparam int HIT_COUNT_WIDTH = 8;   // saturates at 255

   // capture and trigger counters
   localparam int TIMESTAMP_WIDTH = 16;
   localparam int TRIG_DELAY_WIDTH = 16;
   localparam int TRIG_WIDTH_WIDTH = 16;

   // one pattern/mask rule, 130 bits
   typedef struct packed {
      logic [BUFFER_WIDTH-1:0] pattern;
      logic [BUFFER_WIDTH-1:0] mask;         // 1 = bit is compared
      logic                    enable;
      logic                    trig_enable;  // hit may fire the trigger
   } match_rule_t;

   // trigger pulse settings, 32 bits
   typedef struct packed {
      logic [TRIG_DELAY_WIDTH-1:0] trig_delay;  // cycles after hit, minus one
      logic [TRIG_WIDTH_WIDTH-1:0] trig_width;  // 0 gives no pulse
   } trigger_cfg_t;

   // one flag per rule
   typedef logic [NUM_RULES-1:0] hit_vector_t;

   // record emitted per match, 83 bits
   typedef struct packed {
      logic [RULE_INDEX_WIDTH-1:0] rule_index;  // lowest hitting rule
      logic [TIMESTAMP_WIDTH-1:0]  timestamp;   // cycles since arm
      logic [BUFFER_WIDTH-1:0]     match_bytes;
   } capture_record_t;

   // byte order in the buffer
   // bits 7:0 hold the newest byte, bits 63:56 the oldest
   // a byte is {high nibble, low nibble}, low nibble first on the port

endpackage

//--- src/trigger_pulse_gen.sv
// ==================================================
// trigger pulse generator
// one delayed trigger pulse of programmable width
// on the first trigger hit after arm
// ==================================================

`timescale 1ns/1ps

module trigger_pulse_gen (
   input  logic                    trace_clk,
   input  logic                    reset,
   input  logic                    arm,
   input  logic                    trig_hit,
   input  trace_pkg::trigger_cfg_t trig_cfg,
   output logic                    trig_out
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_DELAY,
      S_PULSE,
      S_DONE
   } trig_state_t;

   trig_state_t                            state;
   logic [trace_pkg::TRIG_DELAY_WIDTH-1:0] count;   // shared by delay and width

   always_ff @(posedge trace_clk) begin
      if (reset || !arm) begin
         state <= S_IDLE;   // disarm cancels anything pending
         count <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (trig_hit) begin
                  if (trig_cfg.trig_width == '0) begin
                     state <= S_DONE;   // zero width, nothing to drive
                  end else if (trig_cfg.trig_delay == '0) begin
                     state <= S_PULSE;
                     count <= trig_cfg.trig_width - 1'b1;
                  end else begin
                     state <= S_DELAY;
                     count <= trig_cfg.trig_delay - 1'b1;
                  end
               end
            end
            S_DELAY: begin
               if (count == '0) begin
                  state <= S_PULSE;
                  count <= trig_cfg.trig_width - 1'b1;
               end else begin
                  count <= count - 1'b1;
               end
            end
            S_PULSE: begin
               if (count == '0) state <= S_DONE;
               else count <= count - 1'b1;
            end
            default: ;   // done, later hits ignored until re-arm
         endcase
      end
   end

   assign trig_out = (state == S_PULSE);

   // pulse is gone by the cycle after disarm
   a_no_trig_disarmed: assert property (
      @(posedge trace_clk) disable iff (reset)
      !arm |=> !trig_out
   );

endmodule

//--- tests/tb_clock_gen.sv
// ==================================================
// testbench clock and reset
// 100 ns trace clock, reset held for 10 cycles
// ==================================================

`timescale 1ns/1ps

module tb_clock_gen (
   output logic trace_clk,
   output logic reset
);

   localparam int PERIOD_NS    = 100;
   localparam int RESET_CYCLES = 10;

   initial begin
      trace_clk = 1'b0;
      forever #(PERIOD_NS / 2) trace_clk = !trace_clk;
   end

   // released just after an edge, like the other stimulus
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge trace_clk);
      #1 reset = 1'b0;
   end

endmodule

//--- tests/tb_trace_capture.sv
// ==================================================
// trace capture testbench
// directed tests against a cycle level model of the
// byte buffer, capture records and trigger pulse
// ==================================================

`timescale 1ns/1ps

module tb_trace_capture;

   localparam int TIMEOUT_CYCLES = 40;

   logic                                  trace_clk;
   logic                                  reset;
   logic [trace_pkg::NIBBLE_WIDTH-1:0]    trace_data;
   logic                                  arm;
   trace_pkg::match_rule_t                rules [trace_pkg::NUM_RULES];
   trace_pkg::trigger_cfg_t               trig_cfg;
   logic                                  trig_out;
   logic                                  record_valid;
   trace_pkg::capture_record_t            record;
   logic [trace_pkg::HIT_COUNT_WIDTH-1:0] hit_counts [trace_pkg::NUM_RULES];

   // reference model
   int                                 seed = 32'h2229_f450;
   int                                 cycle;             // cycles since arm
   int                                 last_byte_cycle;   // cycle of the last high nibble
   logic                               model_phase;
   logic [trace_pkg::NIBBLE_WIDTH-1:0] model_low;
   logic [trace_pkg::BUFFER_WIDTH-1:0] model_buf;
   int                                 model_counts [trace_pkg::NUM_RULES];
   int                                 exp_cycles [$];
   trace_pkg::capture_record_t         exp_records [$];
   logic                               trig_seen;
   int                                 trig_start;
   int                                 trig_end;

   tb_clock_gen tb_clock_gen_i (
      .trace_clk (trace_clk),
      .reset     (reset)
   );

   trace_capture_top trace_capture_top_i (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .trace_data   (trace_data),
      .arm          (arm),
      .rules        (rules),
      .trig_cfg     (trig_cfg),
      .trig_out     (trig_out),
      .record_valid (record_valid),
      .record       (record),
      .hit_counts   (hit_counts)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("mismatch at %0t: %s expected 'h%0h, got 'h%0h",
                            $time, name, expected, actual));
      end
   endtask

   // a rule hits when every mask bit agrees with the pattern
   function automatic trace_pkg::hit_vector_t expected_hits(input logic [63:0] window);
      trace_pkg::hit_vector_t hv;
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         hv[i] = rules[i].enable &&
                 ((window & rules[i].mask) == (rules[i].pattern & rules[i].mask));
      end
      return hv;
   endfunction

   function automatic logic [trace_pkg::RULE_INDEX_WIDTH-1:0] lowest_rule(
         input trace_pkg::hit_vector_t hv);
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         if (hv[i]) return i[trace_pkg::RULE_INDEX_WIDTH-1:0];
      end
      return '0;
   endfunction

   task automatic reset_model();
      cycle       = 0;
      model_phase = 1'b0;
      model_low   = '0;
      model_buf   = '0;
      trig_seen   = 1'b0;
      trig_start  = 0;
      trig_end    = 0;
      exp_cycles.delete();
      exp_records.delete();
      foreach (model_counts[i]) model_counts[i] = 0;
   endtask

   // present one nibble for one cycle, then check this cycle's outputs
   task automatic step(input logic [3:0] nib);
      trace_pkg::hit_vector_t     hv;
      trace_pkg::capture_record_t rec;
      logic                       exp_valid;
      logic                       trig_hit;
      trace_data = nib;
      if (arm) begin
         if (model_phase) begin
            model_buf       = {model_buf[55:0], nib, model_low};
            hv              = expected_hits(model_buf);
            last_byte_cycle = cycle;
            trig_hit        = 1'b0;
            for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
               if (hv[i] && model_counts[i] < 255) model_counts[i]++;
               if (hv[i] && rules[i].trig_enable) trig_hit = 1'b1;
            end
            if (hv != '0) begin
               rec.rule_index  = lowest_rule(hv);
               rec.timestamp   = 16'(cycle + 2);   // hit vector cycle
               rec.match_bytes = model_buf;
               exp_cycles.push_back(cycle + 3);
               exp_records.push_back(rec);
            end
            if (trig_hit && !trig_seen) begin
               trig_seen  = 1'b1;
               trig_start = cycle + 3 + int'(trig_cfg.trig_delay);
               trig_end   = trig_start + int'(trig_cfg.trig_width);
            end
         end else begin
            model_low = nib;
         end
         model_phase = !model_phase;
      end
      @(posedge trace_clk);
      #1;
      cycle++;
      exp_valid = (exp_cycles.size() > 0) && (exp_cycles[0] == cycle);
      check_value("record_valid", 64'(exp_valid), 64'(record_valid));
      if (exp_valid) begin
         rec = exp_records.pop_front();
         void'(exp_cycles.pop_front());
         check_value("record.rule_index", 64'(rec.rule_index), 64'(record.rule_index));
         check_value("record.timestamp", 64'(rec.timestamp), 64'(record.timestamp));
         check_value("record.match_bytes", rec.match_bytes, record.match_bytes);
      end
      check_value("trig_out", 64'(trig_seen && cycle >= trig_start && cycle < trig_end),
                  64'(trig_out));
   endtask

   task automatic idle(input int n);
      repeat (n) step(4'h0);
   endtask

   // low nibble first after realigning any pending half byte
   task automatic feed_byte(input logic [7:0] b);
      if (arm && model_phase) step(4'h0);
      step(b[3:0]);
      step(b[7:4]);
   endtask

   task automatic feed_pattern(input logic [63:0] p);
      for (int i = 7; i >= 0; i--) feed_byte(p[i*8 +: 8]);   // oldest byte first
   endtask

   task automatic feed_filler(input int n);
      repeat (n) feed_byte(8'($random(seed)));
   endtask

   task automatic set_rule(input int idx, input logic [63:0] pattern, input logic [63:0] mask,
                           input logic trig_en);
      rules[idx] = {pattern, mask, 1'b1, trig_en};
   endtask

   task automatic clear_rules();
      foreach (rules[i]) rules[i] = '0;
   endtask

   task automatic arm_up();
      reset_model();
      arm = 1'b1;   // this cycle is cycle 0
   endtask

   task automatic arm_down();
      arm = 1'b0;
      reset_model();
      idle(3);
   endtask

   task automatic check_counts();
      for (int i = 0; i < trace_pkg::NUM_RULES; i++) begin
         check_value($sformatf("hit_counts[%0d]", i), 64'(model_counts[i]),
                     64'(hit_counts[i]));
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      @(posedge trace_clk);   // reset is driven by the first edge
      while (reset !== 1'b0 && n < TIMEOUT_CYCLES) begin
         @(posedge trace_clk);
         n++;
      end
      if (reset !== 1'b0) fail_run("reset was never released");
      else #1;
   endtask

   task automatic wait_record(input int limit);
      int n;
      n = 0;
      while (!record_valid && n < limit) begin
         step(4'h0);
         n++;
      end
      if (!record_valid) fail_run("no capture record appeared before the timeout");
   endtask

   task automatic wait_trigger(input int limit);
      int n;
      n = 0;
      while (!trig_out && n < limit) begin
         step(4'h0);
         n++;
      end
      if (!trig_out) fail_run("trig_out never rose before the timeout");
   endtask

   task automatic exact_match_test();
      logic [63:0] pat;
      int          n;
      pat = 64'h1122_3344_5566_7788;
      clear_rules();
      set_rule(2, pat, '1, 1'b0);
      trig_cfg = '0;
      arm_up();
      feed_filler(5);
      feed_pattern(pat);
      n = last_byte_cycle;
      wait_record(TIMEOUT_CYCLES);
      check_value("record cycle", 64'(n + 3), 64'(cycle));
      check_value("record.rule_index", 64'(2), 64'(record.rule_index));
      check_value("record.timestamp", 64'(n + 2), 64'(record.timestamp));
      check_value("record.match_bytes", pat, record.match_bytes);
      idle(10);   // no second record
      check_value("hit_counts[2]", 64'(1), 64'(hit_counts[2]));
      arm_down();
   endtask

   task automatic mask_test();
      logic [63:0] pat;
      logic [63:0] alt;
      pat = 64'hC35A_9E21_6BD4_17E8;
      alt = pat ^ 64'h00AA_0000_0F0F_0000;   // only uncompared bits differ
      clear_rules();
      set_rule(0, pat, 64'hFF00_FFFF_F0F0_FFFF, 1'b0);
      arm_up();
      feed_pattern(pat);
      wait_record(TIMEOUT_CYCLES);
      feed_pattern(alt);
      wait_record(TIMEOUT_CYCLES);
      check_value("record.match_bytes", alt, record.match_bytes);
      feed_pattern(pat ^ 64'h0000_0000_1000_0000);   // compared bit flipped
      idle(12);
      check_value("hit_counts[0]", 64'(2), 64'(hit_counts[0]));
      arm_down();
   endtask

   task automatic priority_test();
      logic [63:0] pat;
      pat = 64'h0F1E_2D3C_4B5A_6978;
      clear_rules();
      set_rule(0, pat, '1, 1'b0);
      rules[0].enable = 1'b0;   // same pattern but disabled
      set_rule(1, pat, '1, 1'b0);
      set_rule(4, pat, '1, 1'b0);
      arm_up();
      repeat (2) begin
         feed_pattern(pat);
         wait_record(TIMEOUT_CYCLES);
         check_value("record.rule_index", 64'(1), 64'(record.rule_index));
      end
      idle(4);
      check_value("hit_counts[0]", 64'(0), 64'(hit_counts[0]));
      check_value("hit_counts[1]", 64'(2), 64'(hit_counts[1]));
      check_value("hit_counts[4]", 64'(2), 64'(hit_counts[4]));
      check_counts();
      arm_down();
   endtask

   task automatic trigger_test();
      logic [63:0] trig_pat;
      logic [63:0] plain_pat;
      int          n;
      int          high;
      trig_pat  = 64'h9A8B_7C6D_5E4F_3021;
      plain_pat = 64'h2468_ACE0_1357_9BDF;
      clear_rules();
      set_rule(5, trig_pat, '1, 1'b1);
      set_rule(6, plain_pat, '1, 1'b0);
      trig_cfg.trig_delay = 16'd3;
      trig_cfg.trig_width = 16'd4;
      arm_up();
      feed_pattern(plain_pat);   // record only
      wait_record(TIMEOUT_CYCLES);
      check_value("record.rule_index", 64'(6), 64'(record.rule_index));
      idle(12);
      feed_pattern(trig_pat);
      n = last_byte_cycle;
      wait_trigger(TIMEOUT_CYCLES);
      check_value("trig_out rise cycle", 64'(n + 2 + 4), 64'(cycle));
      high = 0;
      while (trig_out && high < TIMEOUT_CYCLES) begin
         step(4'h0);
         high++;
      end
      check_value("trig_out width", 64'(4), 64'(high));
      feed_pattern(trig_pat);   // second hit under the same arm
      wait_record(TIMEOUT_CYCLES);
      idle(12);
      arm_down();
   endtask

   task automatic rearm_test();
      logic [63:0] pat;
      int          n;
      pat = 64'h7E81_42BD_24DB_18E7;
      clear_rules();
      set_rule(3, pat, '1, 1'b1);
      trig_cfg.trig_delay = 16'd0;
      trig_cfg.trig_width = 16'd2;
      arm_up();
      feed_filler(3);
      feed_pattern(pat);
      wait_trigger(TIMEOUT_CYCLES);
      idle(4);
      if (!model_phase) step(4'h9);   // leave a half byte behind
      arm_down();
      check_value("hit_counts[3]", 64'(0), 64'(hit_counts[3]));
      check_counts();
      arm_up();
      feed_pattern(pat);
      n = last_byte_cycle;
      wait_record(TIMEOUT_CYCLES);
      check_value("record.timestamp", 64'(n + 2), 64'(record.timestamp));
      wait_trigger(TIMEOUT_CYCLES);
      check_value("trig_out rise cycle", 64'(n + 3), 64'(cycle));
      idle(6);
      arm_down();
   endtask

   initial begin
      trace_data = '0;
      arm        = 1'b0;
      trig_cfg   = '0;
      clear_rules();
      reset_model();
      wait_reset_release();
      check_value("byte_valid", 64'(0), 64'(trace_capture_top_i.byte_valid));
      check_value("record_valid", 64'(0), 64'(record_valid));
      check_value("trig_out", 64'(0), 64'(trig_out));
      check_counts();
      exact_match_test();
      mask_test();
      priority_test();
      trigger_test();
      rearm_test();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
